// ==== Bender.yml ====
package:
  name: i3c_target_core

sources:
  - files:
      - common/i3c_ccc_pkg.sv
      - src/target_frontend.sv
      - ccc/ccc_get_mux.sv
      - ccc/ccc_handler.sv
      - src/target_csr.sv
      - src/i3c_target_core.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_i3c_target_core.sv

// ==== ccc/ccc_get_mux.sv ====
// GET response byte counter and most-significant-first byte selection
module ccc_get_mux (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  i3c_ccc_pkg::byte_t ccc_code_i,
  input  logic               load_i,
  input  logic               advance_i,
  input  i3c_ccc_pkg::byte_t bcr_i,
  input  i3c_ccc_pkg::byte_t dcr_i,
  input  logic [15:0]        status_i,
  input  logic [47:0]        pid_i,
  input  i3c_ccc_pkg::len_t  mwl_i,
  input  i3c_ccc_pkg::len_t  mrl_i,
  output i3c_ccc_pkg::byte_t get_byte_o,
  output logic               get_last_o
);
  import i3c_ccc_pkg::*;

  // Bytes left, 1 on the final byte
  logic [2:0]  cnt_q;
  logic [2:0]  cnt_init;
  logic [47:0] pid_shift;

  always_comb begin
    case (ccc_code_i)
      DirGetbcr, DirGetdcr:    cnt_init = 3'd1;
      DirGetstatus, DirGetmwl: cnt_init = 3'd2;
      DirGetmrl:               cnt_init = 3'd3;
      DirGetpid:               cnt_init = 3'd6;
      default:                 cnt_init = 3'd0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= 3'd0;
    end else if (load_i) begin
      cnt_q <= cnt_init;
    end else if (advance_i && cnt_q != 3'd0) begin
      cnt_q <= cnt_q - 3'd1;
    end
  end

  // PID byte n sits at bits 8n-1 down to 8n-8
  assign pid_shift = pid_i >> {cnt_q - 3'd1, 3'b000};

  always_comb begin
    case (ccc_code_i)
      DirGetbcr:    get_byte_o = bcr_i;
      DirGetdcr:    get_byte_o = dcr_i;
      DirGetstatus: get_byte_o = (cnt_q == 3'd2) ? status_i[15:8] : status_i[7:0];
      DirGetmwl:    get_byte_o = (cnt_q == 3'd2) ? mwl_i[15:8] : mwl_i[7:0];
      // Third MRL byte reads as zero
      DirGetmrl:    get_byte_o = (cnt_q == 3'd3) ? mrl_i[15:8] :
                                 (cnt_q == 3'd2) ? mrl_i[7:0] : 8'h00;
      DirGetpid:    get_byte_o = pid_shift[7:0];
      default:      get_byte_o = 8'h00;
    endcase
  end

  assign get_last_o = (cnt_q == 3'd1);

endmodule

// ==== ccc/ccc_handler.sv ====
// CCC handler FSM: T-bits, direct address match, SET data collection, commit pulse, GET stream
module ccc_handler (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  ccc_valid_i,
  input  i3c_ccc_pkg::byte_t    ccc_code_i,
  input  logic                  bus_start_i,
  input  logic                  bus_stop_i,
  input  logic                  bus_rx_done_i,
  input  i3c_ccc_pkg::byte_t    bus_rx_data_i,
  input  logic                  bus_tx_done_i,
  input  i3c_ccc_pkg::addr_t    static_addr_i,
  input  logic                  static_addr_valid_i,
  input  i3c_ccc_pkg::addr_t    dyn_addr_i,
  input  logic                  dyn_addr_valid_i,
  input  i3c_ccc_pkg::byte_t    bcr_i,
  input  i3c_ccc_pkg::byte_t    dcr_i,
  input  logic [15:0]           status_i,
  input  logic [47:0]           pid_i,
  input  i3c_ccc_pkg::len_t     mwl_i,
  input  i3c_ccc_pkg::len_t     mrl_i,
  output logic                  rx_req_byte_o,
  output logic                  rx_req_bit_o,
  output logic                  tx_req_byte_o,
  output logic                  tx_req_bit_o,
  output i3c_ccc_pkg::byte_t    tx_value_o,
  output logic                  ccc_done_o,
  output i3c_ccc_pkg::ccc_set_t ccc_set_o
);
  import i3c_ccc_pkg::*;

  CccState_e state_q, state_d;
  byte_t     code_q;
  // Address byte after Sr, bit 0 is RnW
  byte_t     addr_q;
  len_t      data_q;
  // SET bytes still expected
  logic [1:0] cnt_q;
  logic [1:0] nbytes;
  set_kind_e kind;
  logic      is_direct, is_get, known;
  logic      is_rsvd, is_ours, addr_ack;
  byte_t     get_byte;
  logic      get_last;

  // Command decode
  always_comb begin
    case (code_q)
      BcastEnec, DirEnec:     kind = SetEnec;
      BcastDisec, DirDisec:   kind = SetDisec;
      BcastRstdaa:            kind = SetRstdaa;
      BcastSetmwl, DirSetmwl: kind = SetMwl;
      BcastSetmrl, DirSetmrl: kind = SetMrl;
      DirSetnewda:            kind = SetNewda;
      default:                kind = SetNone;
    endcase
  end

  assign is_get    = code_q inside {DirGetbcr, DirGetdcr, DirGetstatus,
                                    DirGetmwl, DirGetmrl, DirGetpid};
  assign known     = (kind != SetNone) || is_get;
  assign is_direct = code_q[7];
  // Lengths take two bytes, RSTDAA none
  assign nbytes    = (kind == SetRstdaa) ? 2'd0 :
                     (kind inside {SetMwl, SetMrl}) ? 2'd2 : 2'd1;

  // Dynamic address wins once assigned
  always_comb begin
    if (dyn_addr_valid_i) is_ours = (addr_q[7:1] == dyn_addr_i);
    else if (static_addr_valid_i) is_ours = (addr_q[7:1] == static_addr_i);
    else is_ours = 1'b0;
  end

  assign is_rsvd  = (addr_q == RsvdByte);
  // Direction must fit the command
  assign addr_ack = is_rsvd || (is_ours && (addr_q[0] == is_get));

  always_comb begin
    state_d = state_q;
    case (state_q)
      CcIdle:   if (ccc_valid_i) state_d = CcTbit;
      CcTbit: begin
        if (bus_rx_done_i) begin
          // Unknown codes sit out the rest of the frame
          if (!known || is_direct) state_d = CcWaitSr;
          else if (nbytes == 2'd0) state_d = CcCommit;
          else state_d = CcRxData;
        end
      end
      CcWaitSr: if (bus_start_i && is_direct && known) state_d = CcAddr;
      CcAddr:   if (bus_rx_done_i) state_d = CcAddrAck;
      CcAddrAck: begin
        if (bus_tx_done_i) begin
          if (is_rsvd) state_d = CcDone;
          else if (!addr_ack) state_d = CcWaitSr;
          else if (addr_q[0]) state_d = CcTxData;
          else state_d = CcRxData;
        end
      end
      // Sr mid-transfer drops partial data
      CcRxData: begin
        if (bus_start_i && is_direct) state_d = CcAddr;
        else if (bus_rx_done_i) state_d = CcRxTbit;
      end
      CcRxTbit: if (bus_rx_done_i) state_d = (cnt_q == 2'd0) ? CcCommit : CcRxData;
      CcTxData: begin
        if (bus_start_i) state_d = CcAddr;
        else if (bus_tx_done_i) state_d = CcTxTbit;
      end
      CcTxTbit: if (bus_tx_done_i) state_d = get_last ? CcWaitSr : CcTxData;
      CcCommit: state_d = CcWaitSr;
      CcDone:   state_d = CcIdle;
      default:  state_d = CcIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CcIdle;
      cnt_q   <= 2'd0;
    end else begin
      // Stop ends the CCC from anywhere
      state_q <= bus_stop_i ? CcDone : state_d;
      if (state_q == CcTbit || state_q == CcAddrAck) cnt_q <= nbytes;
      else if (state_q == CcRxData && bus_rx_done_i) cnt_q <= cnt_q - 2'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ccc_valid_i) code_q <= ccc_code_i;
    if (state_q == CcAddr && bus_rx_done_i) addr_q <= bus_rx_data_i;
    // First byte ends up high
    if (state_q == CcRxData && bus_rx_done_i) data_q <= {data_q[7:0], bus_rx_data_i};
  end

  always_comb begin
    rx_req_byte_o = 1'b0;
    rx_req_bit_o  = 1'b0;
    tx_req_byte_o = 1'b0;
    tx_req_bit_o  = 1'b0;
    tx_value_o    = '0;
    case (state_q)
      CcTbit, CcRxTbit:   rx_req_bit_o = 1'b1;
      CcAddr, CcRxData:   rx_req_byte_o = 1'b1;
      CcAddrAck: begin
        tx_req_bit_o = 1'b1;
        tx_value_o   = {7'h00, !addr_ack};
      end
      CcTxData: begin
        tx_req_byte_o = 1'b1;
        tx_value_o    = get_byte;
      end
      // T-bit 0 ends the read
      CcTxTbit: begin
        tx_req_bit_o = 1'b1;
        tx_value_o   = {7'h00, !get_last};
      end
      default:  tx_value_o = '0;
    endcase
  end

  assign ccc_done_o = (state_q == CcDone);

  always_comb begin
    ccc_set_o.valid = (state_q == CcCommit);
    ccc_set_o.kind  = kind;
    case (kind)
      SetMwl, SetMrl: ccc_set_o.data = data_q;
      SetNewda:       ccc_set_o.data = {9'h000, data_q[7:1]};
      default:        ccc_set_o.data = {8'h00, data_q[7:0]};
    endcase
  end

  ccc_get_mux get_mux_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ccc_code_i (code_q),
    .load_i     (state_q == CcAddrAck && bus_tx_done_i),
    .advance_i  (state_q == CcTxTbit && bus_tx_done_i),
    .bcr_i      (bcr_i),
    .dcr_i      (dcr_i),
    .status_i   (status_i),
    .pid_i      (pid_i),
    .mwl_i      (mwl_i),
    .mrl_i      (mrl_i),
    .get_byte_o (get_byte),
    .get_last_o (get_last)
  );

  a_no_rx_tx_overlap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !((rx_req_byte_o || rx_req_bit_o) && (tx_req_byte_o || tx_req_bit_o)));

  a_set_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ccc_set_o.valid |=> !ccc_set_o.valid);

endmodule

// ==== common/i3c_ccc_pkg.sv ====
// CCC codes, address, length and event types, SET struct, FSM state enums and reset values
package i3c_ccc_pkg;

  // Widths fixed by the I3C standard
  typedef logic [7:0]  byte_t;
  typedef logic [6:0]  addr_t;
  typedef logic [15:0] len_t;
  // Event-enable mask, ENEC/DISEC byte layout
  typedef logic [7:0]  evt_t;

  // Broadcast codes, bit 7 clear
  localparam byte_t BcastEnec   = 8'h00;
  localparam byte_t BcastDisec  = 8'h01;
  localparam byte_t BcastRstdaa = 8'h06;
  localparam byte_t BcastSetmwl = 8'h09;
  localparam byte_t BcastSetmrl = 8'h0A;

  // Direct codes, bit 7 set
  localparam byte_t DirEnec      = 8'h80;
  localparam byte_t DirDisec     = 8'h81;
  localparam byte_t DirSetnewda  = 8'h88;
  localparam byte_t DirSetmwl    = 8'h89;
  localparam byte_t DirSetmrl    = 8'h8A;
  localparam byte_t DirGetmwl    = 8'h8B;
  localparam byte_t DirGetmrl    = 8'h8C;
  localparam byte_t DirGetpid    = 8'h8D;
  localparam byte_t DirGetbcr    = 8'h8E;
  localparam byte_t DirGetdcr    = 8'h8F;
  localparam byte_t DirGetstatus = 8'h90;

  // 7E with write bit
  localparam byte_t RsvdByte = 8'hFC;

  // Configuration after reset
  localparam len_t MwlReset = 16'd256;
  localparam len_t MrlReset = 16'd256;
  localparam evt_t EvtReset = 8'hFF;

  // What a committed SET changes
  typedef enum logic [2:0] {
    SetNone,
    SetEnec,
    SetDisec,
    SetRstdaa,
    SetMwl,
    SetMrl,
    SetNewda
  } set_kind_e;

  // Committed SET, valid is a one-cycle pulse
  typedef struct packed {
    logic      valid;
    set_kind_e kind;
    len_t      data;
  } ccc_set_t;

  typedef enum logic [2:0] {
    FeIdle,
    FeHeader,
    FeAck,
    FeCode,
    FeHandoff,
    FeActive,
    FeIgnore
  } FrontendState_e;

  typedef enum logic [3:0] {
    CcIdle,
    CcTbit,
    CcWaitSr,
    CcAddr,
    CcAddrAck,
    CcRxData,
    CcRxTbit,
    CcTxData,
    CcTxTbit,
    CcCommit,
    CcDone
  } CccState_e;

endpackage

// ==== sources.f ====
+incdir+verification
common/i3c_ccc_pkg.sv
src/target_frontend.sv
ccc/ccc_get_mux.sv
ccc/ccc_handler.sv
src/target_csr.sv
src/i3c_target_core.sv
verification/tb_i3c_target_core.sv

// ==== src/i3c_target_core.sv ====
// I3C target core top: front end, CCC handler, configuration registers and bus sharing
module i3c_target_core (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               bus_start_i,
  input  logic               bus_stop_i,
  input  logic               bus_rx_done_i,
  input  i3c_ccc_pkg::byte_t bus_rx_data_i,
  input  logic               bus_tx_done_i,
  output logic               bus_rx_req_byte_o,
  output logic               bus_rx_req_bit_o,
  output logic               bus_tx_req_byte_o,
  output logic               bus_tx_req_bit_o,
  output i3c_ccc_pkg::byte_t bus_tx_value_o,
  input  i3c_ccc_pkg::addr_t static_addr_i,
  input  logic               static_addr_valid_i,
  input  i3c_ccc_pkg::byte_t bcr_i,
  input  i3c_ccc_pkg::byte_t dcr_i,
  input  logic [15:0]        status_i,
  input  logic [47:0]        pid_i,
  output i3c_ccc_pkg::addr_t dyn_addr_o,
  output logic               dyn_addr_valid_o,
  output i3c_ccc_pkg::len_t  mwl_o,
  output i3c_ccc_pkg::len_t  mrl_o,
  output i3c_ccc_pkg::evt_t  evt_en_o
);
  import i3c_ccc_pkg::*;

  logic     fe_rx_req_byte, fe_tx_req_bit;
  logic     ccc_valid, ccc_active, ccc_done;
  byte_t    ccc_code;
  logic     hdl_rx_req_byte, hdl_rx_req_bit, hdl_tx_req_byte, hdl_tx_req_bit;
  byte_t    hdl_tx_value;
  ccc_set_t ccc_set;

  // Only one side requests at a time
  assign bus_rx_req_byte_o = fe_rx_req_byte | hdl_rx_req_byte;
  assign bus_rx_req_bit_o  = hdl_rx_req_bit;
  assign bus_tx_req_byte_o = hdl_tx_req_byte;
  assign bus_tx_req_bit_o  = fe_tx_req_bit | hdl_tx_req_bit;
  // Front end only sends the header ACK
  assign bus_tx_value_o    = ccc_active ? hdl_tx_value : 8'h00;

  target_frontend frontend_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .bus_start_i   (bus_start_i),
    .bus_stop_i    (bus_stop_i),
    .bus_rx_done_i (bus_rx_done_i),
    .bus_rx_data_i (bus_rx_data_i),
    .bus_tx_done_i (bus_tx_done_i),
    .ccc_done_i    (ccc_done),
    .rx_req_byte_o (fe_rx_req_byte),
    .tx_req_bit_o  (fe_tx_req_bit),
    .ccc_valid_o   (ccc_valid),
    .ccc_code_o    (ccc_code),
    .ccc_active_o  (ccc_active)
  );

  ccc_handler handler_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .ccc_valid_i         (ccc_valid),
    .ccc_code_i          (ccc_code),
    .bus_start_i         (bus_start_i),
    .bus_stop_i          (bus_stop_i),
    .bus_rx_done_i       (bus_rx_done_i),
    .bus_rx_data_i       (bus_rx_data_i),
    .bus_tx_done_i       (bus_tx_done_i),
    .static_addr_i       (static_addr_i),
    .static_addr_valid_i (static_addr_valid_i),
    .dyn_addr_i          (dyn_addr_o),
    .dyn_addr_valid_i    (dyn_addr_valid_o),
    .bcr_i               (bcr_i),
    .dcr_i               (dcr_i),
    .status_i            (status_i),
    .pid_i               (pid_i),
    .mwl_i               (mwl_o),
    .mrl_i               (mrl_o),
    .rx_req_byte_o       (hdl_rx_req_byte),
    .rx_req_bit_o        (hdl_rx_req_bit),
    .tx_req_byte_o       (hdl_tx_req_byte),
    .tx_req_bit_o        (hdl_tx_req_bit),
    .tx_value_o          (hdl_tx_value),
    .ccc_done_o          (ccc_done),
    .ccc_set_o           (ccc_set)
  );

  target_csr csr_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .ccc_set_i        (ccc_set),
    .dyn_addr_o       (dyn_addr_o),
    .dyn_addr_valid_o (dyn_addr_valid_o),
    .mwl_o            (mwl_o),
    .mrl_o            (mrl_o),
    .evt_en_o         (evt_en_o)
  );

endmodule

// ==== src/target_csr.sv ====
// Target configuration registers: dynamic address, max lengths and event enables
module target_csr (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  i3c_ccc_pkg::ccc_set_t ccc_set_i,
  output i3c_ccc_pkg::addr_t    dyn_addr_o,
  output logic                  dyn_addr_valid_o,
  output i3c_ccc_pkg::len_t     mwl_o,
  output i3c_ccc_pkg::len_t     mrl_o,
  output i3c_ccc_pkg::evt_t     evt_en_o
);
  import i3c_ccc_pkg::*;

  addr_t dyn_addr_q;
  logic  dyn_addr_valid_q;
  len_t  mwl_q;
  len_t  mrl_q;
  evt_t  evt_q;
  evt_t  set_byte;

  // Low byte carries ENEC/DISEC mask
  assign set_byte = ccc_set_i.data[7:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dyn_addr_q       <= '0;
      dyn_addr_valid_q <= 1'b0;
      mwl_q            <= MwlReset;
      mrl_q            <= MrlReset;
      evt_q            <= EvtReset;
    end else if (ccc_set_i.valid) begin
      case (ccc_set_i.kind)
        SetEnec:   evt_q <= evt_q | set_byte;
        SetDisec:  evt_q <= evt_q & ~set_byte;
        SetRstdaa: dyn_addr_valid_q <= 1'b0;
        SetMwl:    mwl_q <= ccc_set_i.data;
        SetMrl:    mrl_q <= ccc_set_i.data;
        // Renaming only, no first assignment
        SetNewda: begin
          if (dyn_addr_valid_q) begin
            dyn_addr_q       <= ccc_set_i.data[6:0];
            dyn_addr_valid_q <= 1'b1;
          end
        end
        default:   evt_q <= evt_q;
      endcase
    end
  end

  assign dyn_addr_o       = dyn_addr_q;
  assign dyn_addr_valid_o = dyn_addr_valid_q;
  assign mwl_o            = mwl_q;
  assign mrl_o            = mrl_q;
  assign evt_en_o         = evt_q;

endmodule

// ==== src/target_frontend.sv ====
// Target front end: header byte check, broadcast ACK, command code capture and handoff
module target_frontend (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               bus_start_i,
  input  logic               bus_stop_i,
  input  logic               bus_rx_done_i,
  input  i3c_ccc_pkg::byte_t bus_rx_data_i,
  input  logic               bus_tx_done_i,
  input  logic               ccc_done_i,
  output logic               rx_req_byte_o,
  output logic               tx_req_bit_o,
  output logic               ccc_valid_o,
  output i3c_ccc_pkg::byte_t ccc_code_o,
  output logic               ccc_active_o
);
  import i3c_ccc_pkg::*;

  FrontendState_e state_q, state_d;
  byte_t          code_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      FeIdle:    if (bus_start_i) state_d = FeHeader;
      FeHeader: begin
        if (bus_rx_done_i) begin
          // Only 7E/W is ours, anything else waits for Stop
          state_d = (bus_rx_data_i == RsvdByte) ? FeAck : FeIgnore;
        end
      end
      FeAck:     if (bus_tx_done_i) state_d = FeCode;
      FeCode:    if (bus_rx_done_i) state_d = FeHandoff;
      FeHandoff: state_d = FeActive;
      // Handler owns the bus until it hands back
      FeActive:  if (ccc_done_i) state_d = FeIdle;
      default:   state_d = state_q;
    endcase
    // Stop and Start only matter while not handed off
    if (!ccc_active_o) begin
      if (bus_stop_i) state_d = FeIdle;
      else if (bus_start_i) state_d = FeHeader;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FeIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // Command code held for the handler
  always_ff @(posedge clk_i) begin
    if (state_q == FeCode && bus_rx_done_i) begin
      code_q <= bus_rx_data_i;
    end
  end

  assign rx_req_byte_o = (state_q == FeHeader) || (state_q == FeCode);
  // ACK bit, value 0 comes from the top-level mux
  assign tx_req_bit_o  = (state_q == FeAck);
  assign ccc_valid_o   = (state_q == FeHandoff);
  assign ccc_active_o  = (state_q == FeHandoff) || (state_q == FeActive);
  assign ccc_code_o    = code_q;

  // New handoff only after the previous one returned
  a_valid_not_active: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ccc_valid_o |-> !$past(ccc_active_o));

endmodule

// ==== verification/tb_bus_tasks.svh ====
// Controller-side bus tasks: request wait, start, stop, byte and bit transfers, value check
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// Current level of one target request
function automatic logic req_level(input int kind);
  case (kind)
    ReqRxByte: return bus_rx_req_byte_o;
    ReqRxBit:  return bus_rx_req_bit_o;
    ReqTxByte: return bus_tx_req_byte_o;
    default:   return bus_tx_req_bit_o;
  endcase
endfunction

// Bounded wait so a missing request cannot hang the frame
task automatic wait_request(input int kind, output logic seen);
  int n;
  n = 0;
  while (!req_level(kind) && n < ReqWaitCycles) begin
    @(posedge clk_i);
    #1;
    n++;
  end
  seen = req_level(kind);
endtask

// Bus latency of 1 to 4 cycles
task automatic random_delay();
  int d;
  d = 1 + ({$random(seed)} % 4);
  repeat (d) begin
    @(posedge clk_i);
    #1;
  end
endtask

task automatic start_frame();
  bus_start_i = 1'b1;
  @(posedge clk_i);
  #1;
  bus_start_i = 1'b0;
endtask

// Extra cycles let the handler hand the bus back
task automatic stop_frame();
  bus_stop_i = 1'b1;
  @(posedge clk_i);
  #1;
  bus_stop_i = 1'b0;
  repeat (3) begin
    @(posedge clk_i);
    #1;
  end
endtask

// Controller to target, one byte or one bit
task automatic write_item(input int kind, input byte_t value);
  logic seen;
  wait_request(kind, seen);
  if (!seen) begin
    proto_errors++;
    $display("Error at %0t: target did not request data from the controller", $time);
  end else begin
    random_delay();
    bus_rx_data_i = value;
    bus_rx_done_i = 1'b1;
    @(posedge clk_i);
    #1;
    bus_rx_done_i = 1'b0;
  end
endtask

task automatic write_byte(input byte_t b);
  write_item(ReqRxByte, b);
endtask

task automatic write_tbit(input logic t);
  write_item(ReqRxBit, {7'h00, t});
endtask

// Target to controller, value sampled while the request holds it
task automatic read_item(input int kind, output byte_t value, output logic seen);
  wait_request(kind, seen);
  value = '0;
  if (seen) begin
    random_delay();
    value = bus_tx_value_o;
    bus_tx_done_i = 1'b1;
    @(posedge clk_i);
    #1;
    bus_tx_done_i = 1'b0;
  end
endtask

// Received bytes are logged for the GET compare
task automatic read_byte(output byte_t b, output logic seen);
  read_item(ReqTxByte, b, seen);
  if (seen) rd_bytes.push_back(b);
endtask

task automatic read_bit(output logic b, output logic seen);
  byte_t v;
  read_item(ReqTxBit, v, seen);
  b = v[0];
endtask

task automatic check_value(input string name, input logic [47:0] got, input logic [47:0] exp);
  if (got !== exp) begin
    value_errors++;
    $display("FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
  end
endtask

`endif

// ==== verification/tb_i3c_target_core.sv ====
// Testbench for the I3C target core: clock, reset, bus model, reference model, CCC tests, watchdog
module tb_i3c_target_core;
  import i3c_ccc_pkg::*;

  localparam int ClkPeriod     = 4;
  localparam int ResetCycles   = 5;
  // Frames issued below and worst case cycles per frame
  localparam int NumFrames     = 24;
  localparam int FrameCycles   = 160;
  localparam int ReqWaitCycles = 16;
  localparam int ReqRxByte     = 0;
  localparam int ReqRxBit      = 1;
  localparam int ReqTxByte     = 2;
  localparam int ReqTxBit      = 3;

  logic        clk_i, rst_ni;
  logic        bus_start_i, bus_stop_i, bus_rx_done_i, bus_tx_done_i;
  byte_t       bus_rx_data_i, bus_tx_value_o;
  logic        bus_rx_req_byte_o, bus_rx_req_bit_o, bus_tx_req_byte_o, bus_tx_req_bit_o;
  addr_t       static_addr_i, dyn_addr_o;
  logic        static_addr_valid_i, dyn_addr_valid_o;
  byte_t       bcr_i, dcr_i;
  logic [15:0] status_i;
  logic [47:0] pid_i;
  len_t        mwl_o, mrl_o;
  evt_t        evt_en_o;

  integer      seed = 32'hb71a;
  int          value_errors = 0;
  int          proto_errors = 0;
  byte_t       rd_bytes[$];
  // Reference model of the configuration state
  addr_t       m_dyn_addr;
  logic        m_dyn_valid;
  len_t        m_mwl, m_mrl;
  evt_t        m_evt;

  i3c_target_core dut_i (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .bus_start_i(bus_start_i), .bus_stop_i(bus_stop_i),
    .bus_rx_done_i(bus_rx_done_i), .bus_rx_data_i(bus_rx_data_i),
    .bus_tx_done_i(bus_tx_done_i),
    .bus_rx_req_byte_o(bus_rx_req_byte_o), .bus_rx_req_bit_o(bus_rx_req_bit_o),
    .bus_tx_req_byte_o(bus_tx_req_byte_o), .bus_tx_req_bit_o(bus_tx_req_bit_o),
    .bus_tx_value_o(bus_tx_value_o),
    .static_addr_i(static_addr_i), .static_addr_valid_i(static_addr_valid_i),
    .bcr_i(bcr_i), .dcr_i(dcr_i), .status_i(status_i), .pid_i(pid_i),
    .dyn_addr_o(dyn_addr_o), .dyn_addr_valid_o(dyn_addr_valid_o),
    .mwl_o(mwl_o), .mrl_o(mrl_o), .evt_en_o(evt_en_o)
  );

  `include "tb_bus_tasks.svh"

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #((ResetCycles + NumFrames * FrameCycles) * ClkPeriod);
    $display("Watchdog expired: test sequence did not finish in time");
    $display("FAIL: see errors above");
    $finish;
  end

  task automatic model_set(input byte_t code, input len_t data);
    case (code)
      BcastEnec, DirEnec:     m_evt = m_evt | data[7:0];
      BcastDisec, DirDisec:   m_evt = m_evt & ~data[7:0];
      BcastRstdaa:            m_dyn_valid = 1'b0;
      BcastSetmwl, DirSetmwl: m_mwl = data;
      BcastSetmrl, DirSetmrl: m_mrl = data;
      // Rename only, needs an assigned address
      DirSetnewda: if (m_dyn_valid) m_dyn_addr = data[7:1];
      default: ;
    endcase
  endtask

  // GET byte count and value, first byte at the top
  task automatic expected_get(input byte_t code, output int n, output logic [47:0] v);
    case (code)
      DirGetbcr:    begin n = 1; v = bcr_i; end
      DirGetdcr:    begin n = 1; v = dcr_i; end
      DirGetstatus: begin n = 2; v = status_i; end
      DirGetmwl:    begin n = 2; v = m_mwl; end
      DirGetmrl:    begin n = 3; v = {m_mrl, 8'h00}; end
      default:      begin n = 6; v = pid_i; end
    endcase
  endtask

  task automatic check_outputs();
    check_value("mwl_o", mwl_o, m_mwl);
    check_value("mrl_o", mrl_o, m_mrl);
    check_value("evt_en_o", evt_en_o, m_evt);
    check_value("dyn_addr_valid_o", dyn_addr_valid_o, m_dyn_valid);
    check_value("dyn_addr_o", dyn_addr_o, m_dyn_addr);
  endtask

  // Start, 7E/W with ACK, command code and its T-bit
  task automatic ccc_header(input byte_t code);
    logic ack, seen;
    start_frame();
    write_byte(RsvdByte);
    read_bit(ack, seen);
    if (!seen) begin
      proto_errors++;
      $display("Error at %0t: reserved header was not acknowledged", $time);
    end else begin
      check_value("header ACK bit", ack, 1'b0);
    end
    write_byte(code);
    write_tbit(~^code);
  endtask

  task automatic send_data(input len_t data, input int nbytes);
    for (int i = nbytes - 1; i >= 0; i--) begin
      write_byte(data[8*i +: 8]);
      write_tbit(~^data[8*i +: 8]);
    end
  endtask

  task automatic bcast_set(input byte_t code, input len_t data, input int nbytes);
    ccc_header(code);
    send_data(data, nbytes);
    stop_frame();
    model_set(code, data);
    check_outputs();
  endtask

  // Sr plus address byte, returns whether the target ACKed
  task automatic address_phase(input addr_t addr, input logic rnw, input logic expect_ack,
                               output logic acked);
    logic ack, seen;
    start_frame();
    write_byte({addr, rnw});
    read_bit(ack, seen);
    if (!seen) begin
      proto_errors++;
      $display("Error at %0t: target gave no ACK or NACK for address %0h", $time, addr);
    end else begin
      check_value("address ACK bit", ack, !expect_ack);
    end
    acked = seen && (ack == 1'b0);
  endtask

  task automatic direct_set(input byte_t code, input addr_t addr, input len_t data,
                            input int nbytes, input logic expect_ack);
    logic acked;
    ccc_header(code);
    address_phase(addr, 1'b0, expect_ack, acked);
    if (acked) send_data(data, nbytes);
    stop_frame();
    if (expect_ack) model_set(code, data);
    check_outputs();
  endtask

  task automatic direct_get(input byte_t code, input addr_t addr, input logic expect_ack);
    logic        acked, seen, tbit, more;
    byte_t       b;
    int          n;
    logic [47:0] v;
    expected_get(code, n, v);
    ccc_header(code);
    address_phase(addr, 1'b1, expect_ack, acked);
    rd_bytes.delete();
    more = acked && expect_ack;
    // T-bit 1 means another byte follows
    while (more && rd_bytes.size() < 8) begin
      read_byte(b, seen);
      if (seen)
        read_bit(tbit, seen);
      if (!seen) begin
        proto_errors++;
        $display("Error at %0t: GET response for code %0h stopped early", $time, code);
        more = 1'b0;
      end else begin
        check_value("GET T-bit", tbit, rd_bytes.size() < n);
        more = tbit;
      end
    end
    if (expect_ack) begin
      check_value("GET byte count", rd_bytes.size(), n);
      for (int i = 0; i < rd_bytes.size() && i < n; i++)
        check_value($sformatf("GET %0h byte %0d", code, i), rd_bytes[i], v[8*(n-1-i) +: 8]);
    end
    stop_frame();
    check_outputs();
  endtask

  initial begin
    byte_t  hdr;
    addr_t  other;
    logic   seen;
    byte_t  gets[6];
    bus_start_i = 1'b0;
    bus_stop_i = 1'b0;
    bus_rx_done_i = 1'b0;
    bus_rx_data_i = '0;
    bus_tx_done_i = 1'b0;
    rst_ni = 1'b0;
    static_addr_valid_i = 1'b1;
    static_addr_i = $random(seed);
    // 7E is the broadcast address
    if (static_addr_i == 7'h7E) static_addr_i = 7'h2A;
    bcr_i = $random(seed);
    dcr_i = $random(seed);
    status_i = $random(seed);
    pid_i[47:32] = $random(seed);
    pid_i[31:0] = $random(seed);
    m_dyn_addr = '0;
    m_dyn_valid = 1'b0;
    m_mwl = MwlReset;
    m_mrl = MrlReset;
    m_evt = EvtReset;
    repeat (ResetCycles) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Reset values, no request pending
    check_outputs();
    check_value("request outputs",
                {bus_rx_req_byte_o, bus_rx_req_bit_o, bus_tx_req_byte_o, bus_tx_req_bit_o}, 4'h0);

    repeat (2) begin
      bcast_set(BcastSetmwl, $random(seed), 2);
      bcast_set(BcastSetmrl, $random(seed), 2);
      bcast_set(BcastEnec, {8'h00, 8'($random(seed))}, 1);
      bcast_set(BcastDisec, {8'h00, 8'($random(seed))}, 1);
    end

    gets = '{DirGetbcr, DirGetdcr, DirGetstatus, DirGetmwl, DirGetmrl, DirGetpid};
    foreach (gets[i])
      direct_get(gets[i], static_addr_i, 1'b1);

    // No dynamic address yet, so SETNEWDA has no effect
    direct_set(DirSetnewda, static_addr_i, {8'h00, 7'($random(seed)), 1'b0}, 1, 1'b1);
    direct_set(DirSetmwl, static_addr_i, $random(seed), 2, 1'b1);
    direct_set(DirDisec, static_addr_i, {8'h00, 8'($random(seed))}, 1, 1'b1);
    other = $random(seed);
    while (other == static_addr_i || other == 7'h7E)
      other = $random(seed);
    direct_get(DirGetbcr, other, 1'b0);
    direct_set(DirSetmrl, other, $random(seed), 2, 1'b0);

    bcast_set(BcastRstdaa, '0, 0);
    direct_get(DirGetmwl, static_addr_i, 1'b1);

    // Stop after one of two SETMRL bytes
    ccc_header(BcastSetmrl);
    write_byte($random(seed));
    stop_frame();
    check_outputs();

    hdr = $random(seed);
    if (hdr == RsvdByte) hdr = 8'hA4;
    start_frame();
    write_byte(hdr);
    wait_request(ReqTxBit, seen);
    if (seen) begin
      proto_errors++;
      $display("Error at %0t: target acknowledged foreign header %0h", $time, hdr);
    end
    stop_frame();
    check_outputs();

    $display("Summary: %0d value errors, %0d protocol errors", value_errors, proto_errors);
    if (value_errors == 0 && proto_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
